// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // data and address width
    localparam int xlen = 32;

    // access width codes, code 3 behaves as word
    localparam logic [1:0] width_byte = 2'd0;
    localparam logic [1:0] width_half = 2'd1;
    localparam logic [1:0] width_word = 2'd2;

    // exception code as carried down the pipe
    typedef logic [6:0] exp_t;

    localparam exp_t exc_none = 7'h00;
    // misaligned load/store
    localparam exp_t exc_ale  = 7'h09;

    // request held between address generation and cache access
    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] addr;
        logic [3:0]      be;
        logic [xlen-1:0] wdata;
        logic            write;
        logic [1:0]      width;
        logic            sign;
        exp_t            exp;
        // cache is to be used
        logic            access;
    } req_rec_t;

    // result handed to writeback
    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] data;
        exp_t            exp;
    } wb_rec_t;

endpackage

`default_nettype wire

// ==== design/mem_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_addr_gen
    import mem_pkg::*;
(
    input  wire logic [4:0]      in_rd,
    input  wire logic [xlen-1:0] in_base,
    input  wire logic [xlen-1:0] in_imm,
    input  wire logic [xlen-1:0] in_store_data,
    input  wire logic            in_write,
    input  wire logic [1:0]      in_width,
    input  wire logic            in_sign,
    input  wire exp_t            in_exp,
    output logic [xlen-1:0]      addr,
    output logic [3:0]           be,
    output logic [xlen-1:0]      wdata,
    output logic                 access,
    output exp_t                 exp_out,
    output logic [4:0]           rd_out
);

    logic misaligned;

    // effective address
    assign addr = in_base + in_imm;

    // half needs bit 0 clear, word (and code 3) needs both low bits clear
    always_comb begin
        case (in_width)
            width_byte: misaligned = 1'b0;
            width_half: misaligned = addr[0];
            default:    misaligned = |addr[1:0];
        endcase
    end

    // byte enables and store lane replication
    always_comb begin
        case (in_width)
            width_byte: begin
                be    = 4'b0001 << addr[1:0];
                wdata = {4{in_store_data[7:0]}};
            end
            width_half: begin
                be    = addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{in_store_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = in_store_data;
            end
        endcase
    end

    // earlier exception wins over alignment fault
    assign exp_out = (in_exp != exc_none) ? in_exp :
                     misaligned           ? exc_ale : exc_none;

    // only clean requests reach the cache
    assign access = (exp_out == exc_none);

    // stores write no register
    assign rd_out = in_write ? 5'd0 : in_rd;

endmodule

`default_nettype wire

// ==== design/mem_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     hold,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    // valid bit, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves when not held
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_model
    import mem_pkg::*;
#(
    parameter int depth_words = 256,
    parameter int lines       = 8,
    parameter int miss_cycles = 3
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            valid,
    input  wire logic            op,
    input  wire logic [xlen-1:0] addr,
    input  wire logic [3:0]      be,
    input  wire logic [xlen-1:0] wdata,
    output logic                 data_valid,
    output logic [xlen-1:0]      rdata
);

    // index into the line array and the word store
    localparam int idx_w = $clog2(lines);
    localparam int tag_w = xlen - 2 - idx_w;
    localparam int mem_w = $clog2(depth_words);
    localparam int cnt_w = $clog2(miss_cycles + 1);

    // backing word store, byte writable
    logic [xlen-1:0] mem_q [depth_words];

    // tag array plus per-line valid
    logic [tag_w-1:0] tag_q [lines];
    logic [lines-1:0] tag_valid_q;

    // miss penalty counter
    logic [cnt_w-1:0] miss_cnt_q;

    logic [xlen-3:0]  word_addr;
    logic [xlen-3:0]  word_mod;
    logic [mem_w-1:0] mem_idx;
    logic [idx_w-1:0] line_idx;
    logic [tag_w-1:0] line_tag;
    logic             hit;
    logic             miss;
    logic             fill;

    // word address, byte offset dropped
    assign word_addr = addr[xlen-1:2];
    // wrap into the backing store
    assign word_mod  = word_addr % (xlen-2)'(depth_words);
    assign mem_idx   = word_mod[mem_w-1:0];

    // low word bits pick the line, the rest is the tag
    assign line_idx  = word_addr[idx_w-1:0];
    assign line_tag  = word_addr[xlen-3:idx_w];

    assign hit  = valid && tag_valid_q[line_idx] && (tag_q[line_idx] == line_tag);
    assign miss = valid && !hit;
    // last penalty cycle, line becomes present at this edge
    assign fill = miss && (miss_cnt_q == cnt_w'(miss_cycles - 1));

    // same-cycle answer on hit
    assign data_valid = hit;
    assign rdata      = mem_q[mem_idx];

    // count out the miss penalty
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss_cnt_q <= '0;
        end else if (fill) begin
            miss_cnt_q <= '0;
        end else if (miss) begin
            miss_cnt_q <= miss_cnt_q + 1'b1;
        end
    end

    // line valid bits, all invalid after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_valid_q <= '0;
        end else if (fill) begin
            tag_valid_q[line_idx] <= 1'b1;
        end
    end

    // tag written on fill, loads and stores both allocate
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[line_idx] <= line_tag;
        end
    end

    // store completes on the hit edge, enabled bytes only
    always_ff @(posedge clk) begin
        if (hit && op) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem_q[mem_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_resp_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_resp_stage
    import mem_pkg::*;
(
    input  wire logic            req_valid,
    input  wire logic            access,
    input  wire logic            write,
    input  wire logic [1:0]      width,
    input  wire logic            sign,
    input  wire logic [1:0]      addr_low,
    input  wire logic [4:0]      rd,
    input  wire exp_t            exp,
    input  wire logic            data_valid,
    input  wire logic [xlen-1:0] rdata,
    output logic                 stall,
    output logic [4:0]           wb_rd,
    output logic [xlen-1:0]      wb_data,
    output exp_t                 wb_exp
);

    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [xlen-1:0] load_data;
    logic            is_load;

    // hold the pipe until the cache answers
    assign stall = req_valid && access && !data_valid;

    // addressed lane from the fetched word
    assign byte_sel = rdata[{addr_low, 3'b000} +: 8];
    assign half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0];

    // sign or zero extension per width
    always_comb begin
        case (width)
            width_byte: begin
                load_data = {{(xlen-8){sign & byte_sel[7]}}, byte_sel};
            end
            width_half: begin
                load_data = {{(xlen-16){sign & half_sel[15]}}, half_sel};
            end
            default: begin
                load_data = rdata;
            end
        endcase
    end

    // only a clean load returns data
    assign is_load = req_valid && !write && (exp == exc_none);

    // stores and faults write back zero
    assign wb_data = is_load ? load_data : '0;
    // no destination without a request
    assign wb_rd   = req_valid ? rd : 5'd0;
    assign wb_exp  = req_valid ? exp : exc_none;

endmodule

`default_nettype wire

// ==== design/mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top
    import mem_pkg::*;
#(
    parameter int depth_words = 256,
    parameter int lines       = 8,
    parameter int miss_cycles = 3
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            in_valid,
    input  wire logic [4:0]      in_rd,
    input  wire logic [xlen-1:0] in_base,
    input  wire logic [xlen-1:0] in_imm,
    input  wire logic [xlen-1:0] in_store_data,
    input  wire logic            in_write,
    input  wire logic [1:0]      in_width,
    input  wire logic            in_sign,
    input  wire exp_t            in_exp,
    output logic                 stall,
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output logic [xlen-1:0]      wb_data,
    output exp_t                 wb_exp
);

    // address generator outputs
    logic [xlen-1:0] gen_addr;
    logic [3:0]      gen_be;
    logic [xlen-1:0] gen_wdata;
    logic            gen_access;
    exp_t            gen_exp;
    logic [4:0]      gen_rd;

    // stage records
    req_rec_t req_in;
    req_rec_t req_q;
    logic     req_valid;
    wb_rec_t  wb_in;
    wb_rec_t  wb_q;

    // cache side
    logic            cache_valid;
    logic            cache_data_valid;
    logic [xlen-1:0] cache_rdata;

    mem_addr_gen addr_gen_i (
        .in_rd         (in_rd),
        .in_base       (in_base),
        .in_imm        (in_imm),
        .in_store_data (in_store_data),
        .in_write      (in_write),
        .in_width      (in_width),
        .in_sign       (in_sign),
        .in_exp        (in_exp),
        .addr          (gen_addr),
        .be            (gen_be),
        .wdata         (gen_wdata),
        .access        (gen_access),
        .exp_out       (gen_exp),
        .rd_out        (gen_rd)
    );

    // pack request fields
    assign req_in = '{rd: gen_rd, addr: gen_addr, be: gen_be, wdata: gen_wdata,
                      write: in_write, width: in_width, sign: in_sign,
                      exp: gen_exp, access: gen_access};

    // request register, frozen during stall
    mem_stage_reg #(.payload_t(req_rec_t)) stage0_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (stall),
        .in_valid  (in_valid),
        .in_data   (req_in),
        .out_valid (req_valid),
        .out_data  (req_q)
    );

    // faulted requests stay away from the cache
    assign cache_valid = req_valid && req_q.access;

    dcache_model #(
        .depth_words (depth_words),
        .lines       (lines),
        .miss_cycles (miss_cycles)
    ) dcache_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (cache_valid),
        .op         (req_q.write),
        .addr       (req_q.addr),
        .be         (req_q.be),
        .wdata      (req_q.wdata),
        .data_valid (cache_data_valid),
        .rdata      (cache_rdata)
    );

    mem_resp_stage resp_i (
        .req_valid  (req_valid),
        .access     (req_q.access),
        .write      (req_q.write),
        .width      (req_q.width),
        .sign       (req_q.sign),
        .addr_low   (req_q.addr[1:0]),
        .rd         (req_q.rd),
        .exp        (req_q.exp),
        .data_valid (cache_data_valid),
        .rdata      (cache_rdata),
        .stall      (stall),
        .wb_rd      (wb_in.rd),
        .wb_data    (wb_in.data),
        .wb_exp     (wb_in.exp)
    );

    // writeback register, one-cycle valid per completed request
    mem_stage_reg #(.payload_t(wb_rec_t)) stage1_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (1'b0),
        .in_valid  (req_valid && !stall),
        .in_data   (wb_in),
        .out_valid (wb_valid),
        .out_data  (wb_q)
    );

    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.data;
    assign wb_exp  = wb_q.exp;

endmodule

`default_nettype wire

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import mem_pkg::*;
();

    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int depth_words  = 64;
    localparam int lines        = 4;
    localparam int miss_cycles  = 3;
    localparam int n_entries    = 29;

    // one table row, rnd selects xorshift store data
    typedef struct packed {
        logic            write;
        logic [1:0]      width;
        logic            sign;
        logic [4:0]      rd;
        logic [xlen-1:0] base;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] data;
        logic            rnd;
        exp_t            exp;
    } entry_t;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic [4:0]      in_rd;
    logic [xlen-1:0] in_base;
    logic [xlen-1:0] in_imm;
    logic [xlen-1:0] in_store_data;
    logic            in_write;
    logic [1:0]      in_width;
    logic            in_sign;
    exp_t            in_exp;
    logic            stall;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;
    exp_t            wb_exp;

    entry_t          table_q [n_entries];
    int              n_put;
    logic [31:0]     rng_state;

    // byte image of the backing store
    logic [7:0]      shadow [depth_words*4];
    // expected tag state, direct mapped
    logic            tag_ok [lines];
    logic [31:0]     tag_v [lines];

    mem_stage_top #(
        .depth_words (depth_words),
        .lines       (lines),
        .miss_cycles (miss_cycles)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_rd         (in_rd),
        .in_base       (in_base),
        .in_imm        (in_imm),
        .in_store_data (in_store_data),
        .in_write      (in_write),
        .in_width      (in_width),
        .in_sign       (in_sign),
        .in_exp        (in_exp),
        .stall         (stall),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_exp        (wb_exp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    // generous bound, worst case is a miss per row
    initial begin
        #((n_entries * (miss_cycles + 6) + reset_cycles) * clk_period);
        $display("timeout: the pipeline did not finish all table rows in time");
        $display("*** FAILED ***");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
        if (got !== expv) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, expv);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic put_entry(input logic w, input logic [1:0] wd, input logic sg,
                             input logic [4:0] rd, input logic [31:0] base,
                             input logic [31:0] imm, input logic [31:0] data,
                             input logic rnd, input exp_t exp);
        table_q[n_put] = '{write: w, width: wd, sign: sg, rd: rd, base: base, imm: imm,
                           data: data, rnd: rnd, exp: exp};
        n_put++;
    endtask

    // first byte of the word, wraps like the backing store
    function automatic int byte_base(input logic [31:0] addr);
        return ((addr >> 2) % depth_words) * 4;
    endfunction

    task automatic run_entry(input entry_t e);
        logic [31:0] sdata;
        logic [31:0] addr;
        logic [31:0] exp_data;
        logic [31:0] word;
        logic [15:0] half;
        logic [7:0]  bval;
        logic [4:0]  exp_rd;
        exp_t        exp_code;
        logic        mis;
        logic        miss;
        logic        seen_stall;
        int          bb;
        int          lane;
        int          line;
        int          cycles;
        sdata = e.data;
        if (e.rnd) begin
            rng_state = xorshift(rng_state);
            sdata = rng_state;
        end
        addr = e.base + e.imm;
        bb   = byte_base(addr);
        lane = addr[1:0];
        case (e.width)
            2'd0:    mis = 1'b0;
            2'd1:    mis = addr[0];
            default: mis = |addr[1:0];
        endcase
        // incoming code wins over alignment
        exp_code = (e.exp != exc_none) ? e.exp : (mis ? exc_ale : exc_none);
        exp_rd   = e.write ? 5'd0 : e.rd;
        exp_data = '0;
        miss     = 1'b0;
        if (exp_code == exc_none) begin
            line = (addr >> 2) % lines;
            miss = !tag_ok[line] || (tag_v[line] != ((addr >> 2) / lines));
            tag_ok[line] = 1'b1;
            tag_v[line]  = (addr >> 2) / lines;
            word = {shadow[bb+3], shadow[bb+2], shadow[bb+1], shadow[bb]};
            bval = shadow[bb+lane];
            half = addr[1] ? word[31:16] : word[15:0];
            if (e.write) begin
                case (e.width)
                    2'd0: shadow[bb+lane] = sdata[7:0];
                    2'd1: begin
                        shadow[bb+(lane & 2)]   = sdata[7:0];
                        shadow[bb+(lane & 2)+1] = sdata[15:8];
                    end
                    default: begin
                        for (int k = 0; k < 4; k++) begin
                            shadow[bb+k] = sdata[8*k +: 8];
                        end
                    end
                endcase
            end else begin
                case (e.width)
                    2'd0:    exp_data = {{24{e.sign & bval[7]}}, bval};
                    2'd1:    exp_data = {{16{e.sign & half[15]}}, half};
                    default: exp_data = word;
                endcase
            end
        end
        // one-cycle strobe, pipe is empty here
        @(posedge clk);
        in_valid      <= 1'b1;
        in_rd         <= e.rd;
        in_base       <= e.base;
        in_imm        <= e.imm;
        in_store_data <= sdata;
        in_write      <= e.write;
        in_width      <= e.width;
        in_sign       <= e.sign;
        in_exp        <= e.exp;
        @(posedge clk);
        in_valid <= 1'b0;
        cycles     = 0;
        seen_stall = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            seen_stall = seen_stall | stall;
        end while (!wb_valid);
        check("wb_rd", wb_rd, exp_rd);
        check("wb_data", wb_data, exp_data);
        check("wb_exp", wb_exp, exp_code);
        // a miss must show stall before the result
        check("stall_seen", seen_stall, miss);
        check("latency", cycles, miss ? 2 + miss_cycles : 2);
        @(negedge clk);
        check("wb_valid", wb_valid, 1'b0);
        // pipe drained, next strobe may follow
        check("stall", stall, 1'b0);
    endtask

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_rd         = '0;
        in_base       = '0;
        in_imm        = '0;
        in_store_data = '0;
        in_write      = 1'b0;
        in_width      = 2'd0;
        in_sign       = 1'b0;
        in_exp        = exc_none;
        rng_state     = 32'h7ee6_a1c2;
        n_put         = 0;
        for (int i = 0; i < lines; i++) begin
            tag_ok[i] = 1'b0;
            tag_v[i]  = '0;
        end
        // word store then load back
        put_entry(1, 2'd2, 0, 0, 32'h0, 32'h10, 32'h0, 1, exc_none);
        put_entry(0, 2'd2, 0, 5, 32'h10, 32'h0, 32'h0, 0, exc_none);
        // lane merging into one word
        put_entry(1, 2'd2, 0, 0, 32'h20, 32'h0, 32'h80ff_7f01, 0, exc_none);
        put_entry(1, 2'd0, 0, 0, 32'h20, 32'h1, 32'h0000_00a5, 0, exc_none);
        put_entry(1, 2'd0, 0, 0, 32'h20, 32'h3, 32'h0000_007e, 0, exc_none);
        put_entry(1, 2'd0, 0, 0, 32'h20, 32'h0, 32'h0000_00c3, 0, exc_none);
        put_entry(1, 2'd1, 0, 0, 32'h20, 32'h2, 32'h0000_8001, 0, exc_none);
        put_entry(0, 2'd0, 1, 6, 32'h20, 32'h1, 32'h0, 0, exc_none);
        put_entry(0, 2'd0, 0, 7, 32'h20, 32'h1, 32'h0, 0, exc_none);
        put_entry(0, 2'd1, 1, 8, 32'h20, 32'h2, 32'h0, 0, exc_none);
        put_entry(0, 2'd1, 0, 9, 32'h20, 32'h2, 32'h0, 0, exc_none);
        put_entry(0, 2'd2, 0, 10, 32'h20, 32'h0, 32'h0, 0, exc_none);
        put_entry(0, 2'd0, 1, 11, 32'h20, 32'h0, 32'h0, 0, exc_none);
        put_entry(1, 2'd2, 0, 0, 32'h24, 32'h0, 32'h0, 1, exc_none);
        put_entry(1, 2'd1, 0, 0, 32'h24, 32'h0, 32'h0, 1, exc_none);
        put_entry(1, 2'd0, 0, 0, 32'h24, 32'h2, 32'h0000_0096, 0, exc_none);
        put_entry(0, 2'd1, 1, 12, 32'h24, 32'h2, 32'h0, 0, exc_none);
        put_entry(0, 2'd2, 0, 13, 32'h24, 32'h0, 32'h0, 0, exc_none);
        // misaligned half load and word store
        put_entry(0, 2'd1, 0, 14, 32'h24, 32'h1, 32'h0, 0, exc_none);
        put_entry(1, 2'd2, 0, 0, 32'h24, 32'h2, 32'hdead_beef, 0, exc_none);
        put_entry(0, 2'd2, 0, 15, 32'h24, 32'h0, 32'h0, 0, exc_none);
        // incoming exceptions bypass the cache
        put_entry(0, 2'd2, 0, 16, 32'h24, 32'h0, 32'h0, 0, 7'h05);
        put_entry(1, 2'd2, 0, 0, 32'h10, 32'h0, 32'h1111_1111, 0, 7'h07);
        // negative offsets and same index with other tags
        put_entry(0, 2'd2, 0, 17, 32'h130, 32'hffff_fee0, 32'h0, 0, exc_none);
        put_entry(1, 2'd2, 0, 0, 32'h110, 32'h0, 32'h0, 1, exc_none);
        put_entry(0, 2'd2, 0, 18, 32'h18, 32'hffff_fff8, 32'h0, 0, exc_none);
        put_entry(0, 2'd1, 0, 19, 32'h112, 32'h0, 32'h0, 0, exc_none);
        put_entry(0, 2'd0, 1, 20, 32'h100, 32'h13, 32'h0, 0, exc_none);
        // width code 3 acts as word
        put_entry(0, 2'd3, 0, 21, 32'h20, 32'h0, 32'h0, 0, exc_none);
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            run_entry(table_q[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/mem_pkg.sv
design/mem_addr_gen.sv
design/mem_stage_reg.sv
design/dcache_model.sv
design/mem_resp_stage.sv
design/mem_stage_top.sv
tests/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - design/mem_pkg.sv
  - design/mem_addr_gen.sv
  - design/mem_stage_reg.sv
  - design/dcache_model.sv
  - design/mem_resp_stage.sv
  - design/mem_stage_top.sv
  - target: test
    files:
      - tests/tb_mem_stage.sv
